// ==== Bender.yml ====
package:
  name: int_vect

sources:
  - files:
      - source/iv_ctrl_pkg.sv
      - source/iv_psw_pkg.sv
      - source/pic_request_latch.sv
      - source/iv_step_counter.sv
      - source/int_vect_entry.sv
      - source/iv_control_register.sv
      - source/int_vect_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/int_vect_tb.sv

// ==== project.f ====
+incdir+tb
source/iv_ctrl_pkg.sv
source/iv_psw_pkg.sv
source/pic_request_latch.sv
source/iv_step_counter.sv
source/int_vect_entry.sv
source/iv_control_register.sv
source/int_vect_top.sv
tb/int_vect_tb.sv

// ==== source/int_vect_entry.sv ====
`default_nettype none

module int_vect_entry #(
	parameter int STEP_W = 4
) (
	input  iv_ctrl_pkg::seq_kind_e kind,
	input  logic [STEP_W-1:0]      step,
	output logic                   seq_done,			// Last step of the sequence
	output logic                   operands,			// Operands come from this block
	output logic                   word_byte,			// 0 selects a word access
	output logic                   inc_iv,
	output logic                   dec_iv,
	output logic                   prpo_iv,				// 1 pre-increment, 0 post-decrement
	output logic                   iv_cpu_rst,			// CPU cycle restarts at 5 instead of 1
	output logic                   psw_entry_update,	// Stored priority goes to prev_pri of new PSW
	output logic                   clear_cex,
	output logic                   load_cex,			// CEX state loaded from MDR
	output logic                   clr_slp_bit,
	output logic                   rec_pre_pri,			// Record the running priority
	output logic                   call_pri_flt,
	output logic                   use_pic_vect,		// Vector number taken from the PIC input
	output logic [6:0]             inst_type,
	output logic [1:0]             psw_ent,
	output logic [1:0]             psw_bus_ctrl_iv,
	output logic [6:0]             data_bus_ctrl_iv,
	output logic [6:0]             addr_bus_ctrl_iv,
	output logic [4:0]             data_src_iv,
	output logic [4:0]             addr_src_iv,
	output logic [4:0]             data_dst_iv
);
	import iv_ctrl_pkg::*;

	logic active;

	assign active = (step != '0) && (kind != seq_idle);

	always_comb begin
		seq_done         = 1'b0;
		word_byte        = 1'b0;
		inc_iv           = 1'b0;
		dec_iv           = 1'b0;
		prpo_iv          = 1'b0;
		psw_entry_update = 1'b0;
		clear_cex        = 1'b0;
		load_cex         = 1'b0;
		clr_slp_bit      = 1'b0;
		rec_pre_pri      = 1'b0;
		call_pri_flt     = 1'b0;
		use_pic_vect     = 1'b0;
		inst_type        = inst_invalid;
		psw_ent          = psw_ent_psw;
		psw_bus_ctrl_iv  = psw_bus_idle;
		data_bus_ctrl_iv = bus_idle;
		addr_bus_ctrl_iv = bus_idle;
		data_src_iv      = '0;
		addr_src_iv      = '0;
		data_dst_iv      = '0;

		case (kind)
			seq_entry, seq_entry_fault: begin
				case (step)
					1: begin						// Vector PSW into temp
						inst_type        = inst_ld_w;
						data_bus_ctrl_iv = dbus_mdr_in;
						addr_bus_ctrl_iv = abus_vector;
						data_dst_iv      = reg_temp;
					end
					2: begin
						if (kind == seq_entry_fault) begin	// Priority fault ends the entry
							call_pri_flt = 1'b1;
							seq_done     = 1'b1;
						end else begin						// Push PC
							inst_type        = inst_st_w;
							dec_iv           = 1'b1;
							data_bus_ctrl_iv = dbus_to_mdr;
							addr_bus_ctrl_iv = abus_sp;
							addr_src_iv      = reg_sp;
							data_src_iv      = reg_pc;
							data_dst_iv      = reg_sp;		// SP written back after decrement
						end
					end
					3, 4, 5: begin					// Push LR, PSW, then CEX
						inst_type        = inst_st_w;
						dec_iv           = 1'b1;
						addr_bus_ctrl_iv = abus_sp;
						addr_src_iv      = reg_sp;
						data_src_iv      = reg_lr;
						data_dst_iv      = reg_sp;
						if (step == 3) begin
							data_bus_ctrl_iv = dbus_to_mdr;
						end else if (step == 4) begin
							data_bus_ctrl_iv = dbus_psw_to_mdr;
						end else begin
							data_bus_ctrl_iv = dbus_cex_to_mdr;
							rec_pre_pri      = 1'b1;
						end
					end
					6: begin						// Temp into PSW
						psw_bus_ctrl_iv = psw_from_temp;
						data_src_iv     = reg_temp;
					end
					7: begin						// Entry point into PC
						inst_type        = inst_ld_w;
						psw_entry_update = 1'b1;
						clr_slp_bit      = 1'b1;
						data_bus_ctrl_iv = dbus_mdr_in;
						addr_bus_ctrl_iv = abus_vector;
						psw_ent          = psw_ent_entry;
						data_dst_iv      = reg_pc;
					end
					8: begin						// LR = #FFFF marks the handler return
						inst_type        = inst_mov_w;
						data_bus_ctrl_iv = dbus_reg_move;
						data_src_iv      = reg_const_m1;
						data_dst_iv      = reg_lr;
					end
					9: begin
						clear_cex = 1'b1;
						seq_done  = 1'b1;
					end
					default: ;
				endcase
			end
			seq_return_pop: begin
				if ((step >= 1) && (step <= 5) && (step != 3)) begin	// Pops off the stack
					inst_type        = inst_ld_w;
					prpo_iv          = 1'b1;
					inc_iv           = 1'b1;
					addr_bus_ctrl_iv = abus_sp;
					addr_src_iv      = reg_sp;
					data_src_iv      = reg_sp;
				end
				case (step)
					1: begin						// CEX state
						load_cex         = 1'b1;
						data_bus_ctrl_iv = dbus_none;
						data_dst_iv      = reg_sp;
					end
					2: begin						// PSW straight from MDR
						data_bus_ctrl_iv = dbus_none;
						psw_bus_ctrl_iv  = psw_from_mdr;
						data_src_iv      = '0;
						data_dst_iv      = reg_sp;
					end
					3: clr_slp_bit = 1'b1;
					4: begin						// LR
						data_bus_ctrl_iv = dbus_mdr_in;
						data_dst_iv      = reg_lr;
					end
					5: begin						// PC
						data_bus_ctrl_iv = dbus_mdr_in;
						data_dst_iv      = reg_pc;
						seq_done         = 1'b1;
					end
					default: ;
				endcase
			end
			seq_return_chain: begin
				case (step)
					1: rec_pre_pri = 1'b1;			// Stacked state stays, only priority is kept
					2: begin						// PIC vector PSW into temp
						inst_type        = inst_ld_w;
						use_pic_vect     = 1'b1;
						data_bus_ctrl_iv = dbus_mdr_in;
						addr_bus_ctrl_iv = abus_vector;
						data_dst_iv      = reg_temp;
					end
					3: begin
						psw_bus_ctrl_iv  = psw_from_temp;
						data_src_iv      = reg_temp;
						psw_entry_update = 1'b1;
						clr_slp_bit      = 1'b1;
					end
					4: begin						// Entry point into PC
						inst_type        = inst_ld_w;
						data_bus_ctrl_iv = dbus_mdr_in;
						addr_bus_ctrl_iv = abus_vector;
						psw_ent          = psw_ent_entry;
						data_dst_iv      = reg_pc;
						seq_done         = 1'b1;
					end
					default: ;
				endcase
			end
			default: ;
		endcase

		operands   = active & ~seq_done;	// Decoder regains control on the last step
		iv_cpu_rst = active & ~seq_done;
	end

endmodule

`default_nettype wire

// ==== source/int_vect_top.sv ====
`default_nettype none

module int_vect_top #(
	parameter int STEP_W = 4
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                iv_enter,
	input  logic                iv_return,
	input  logic                svc_inst,
	input  iv_psw_pkg::iv_psw_u cur_psw,
	input  iv_psw_pkg::iv_psw_u vect_psw,
	input  logic [7:0]          pic_in,
	input  logic                stall,
	output logic                busy,
	output logic                operands, word_byte, inc_iv, dec_iv, prpo_iv,
	output logic                iv_cpu_rst, psw_entry_update, clear_cex, load_cex,
	output logic                clr_slp_bit, rec_pre_pri, call_pri_flt, use_pic_vect,
	output logic [6:0]          inst_type, data_bus_ctrl_iv, addr_bus_ctrl_iv,
	output logic [1:0]          psw_ent, psw_bus_ctrl_iv,
	output logic [4:0]          data_src_iv, addr_src_iv, data_dst_iv
);
	import iv_ctrl_pkg::*;

	seq_kind_e         kind;
	logic              start;
	logic              seq_done;
	logic [STEP_W-1:0] step;

	// Unregistered control word between decoder and output register
	logic       operands_d, word_byte_d, inc_iv_d, dec_iv_d, prpo_iv_d;
	logic       iv_cpu_rst_d, psw_entry_update_d, clear_cex_d, load_cex_d;
	logic       clr_slp_bit_d, rec_pre_pri_d, call_pri_flt_d, use_pic_vect_d;
	logic [6:0] inst_type_d, data_bus_ctrl_iv_d, addr_bus_ctrl_iv_d;
	logic [1:0] psw_ent_d, psw_bus_ctrl_iv_d;
	logic [4:0] data_src_iv_d, addr_src_iv_d, data_dst_iv_d;

	pic_request_latch i_latch (
		.clk, .rst, .iv_enter, .iv_return, .svc_inst,
		.cur_psw, .vect_psw, .pic_in, .busy, .start, .kind
	);

	iv_step_counter #(.STEP_W(STEP_W)) i_counter (
		.clk, .rst, .start, .stall, .seq_done, .step, .busy
	);

	int_vect_entry #(.STEP_W(STEP_W)) i_decode (
		.kind, .step, .seq_done,
		.operands(operands_d), .word_byte(word_byte_d),
		.inc_iv(inc_iv_d), .dec_iv(dec_iv_d), .prpo_iv(prpo_iv_d),
		.iv_cpu_rst(iv_cpu_rst_d), .psw_entry_update(psw_entry_update_d),
		.clear_cex(clear_cex_d), .load_cex(load_cex_d),
		.clr_slp_bit(clr_slp_bit_d), .rec_pre_pri(rec_pre_pri_d),
		.call_pri_flt(call_pri_flt_d), .use_pic_vect(use_pic_vect_d),
		.inst_type(inst_type_d), .psw_ent(psw_ent_d), .psw_bus_ctrl_iv(psw_bus_ctrl_iv_d),
		.data_bus_ctrl_iv(data_bus_ctrl_iv_d), .addr_bus_ctrl_iv(addr_bus_ctrl_iv_d),
		.data_src_iv(data_src_iv_d), .addr_src_iv(addr_src_iv_d),
		.data_dst_iv(data_dst_iv_d)
	);

	iv_control_register i_ctrl_reg (.*);	// Same names on both sides, _d into plain

endmodule

`default_nettype wire

// ==== source/iv_control_register.sv ====
`default_nettype none

module iv_control_register (
	input  logic       clk,
	input  logic       rst,
	input  logic       operands_d, word_byte_d, inc_iv_d, dec_iv_d, prpo_iv_d,
	input  logic       iv_cpu_rst_d, psw_entry_update_d, clear_cex_d, load_cex_d,
	input  logic       clr_slp_bit_d, rec_pre_pri_d, call_pri_flt_d, use_pic_vect_d,
	input  logic [6:0] inst_type_d, data_bus_ctrl_iv_d, addr_bus_ctrl_iv_d,
	input  logic [1:0] psw_ent_d, psw_bus_ctrl_iv_d,
	input  logic [4:0] data_src_iv_d, addr_src_iv_d, data_dst_iv_d,
	output logic       operands, word_byte, inc_iv, dec_iv, prpo_iv,
	output logic       iv_cpu_rst, psw_entry_update, clear_cex, load_cex,
	output logic       clr_slp_bit, rec_pre_pri, call_pri_flt, use_pic_vect,
	output logic [6:0] inst_type, data_bus_ctrl_iv, addr_bus_ctrl_iv,
	output logic [1:0] psw_ent, psw_bus_ctrl_iv,
	output logic [4:0] data_src_iv, addr_src_iv, data_dst_iv
);
	import iv_ctrl_pkg::*;

	always_ff @(posedge clk) begin
		if (rst) begin									// Idle word, datapath keeps its own decode
			{operands, word_byte, inc_iv, dec_iv, prpo_iv, iv_cpu_rst} <= '0;
			{psw_entry_update, clear_cex, load_cex, clr_slp_bit} <= '0;
			{rec_pre_pri, call_pri_flt, use_pic_vect} <= '0;
			inst_type        <= inst_invalid;
			psw_ent          <= psw_ent_psw;
			psw_bus_ctrl_iv  <= psw_bus_idle;
			data_bus_ctrl_iv <= bus_idle;
			addr_bus_ctrl_iv <= bus_idle;
			{data_src_iv, addr_src_iv, data_dst_iv} <= '0;
		end else begin									// Loaded every cycle, a stall repeats the word
			{operands, word_byte, inc_iv, dec_iv, prpo_iv, iv_cpu_rst} <=
				{operands_d, word_byte_d, inc_iv_d, dec_iv_d, prpo_iv_d, iv_cpu_rst_d};
			{psw_entry_update, clear_cex, load_cex, clr_slp_bit} <=
				{psw_entry_update_d, clear_cex_d, load_cex_d, clr_slp_bit_d};
			{rec_pre_pri, call_pri_flt, use_pic_vect} <=
				{rec_pre_pri_d, call_pri_flt_d, use_pic_vect_d};
			inst_type        <= inst_type_d;
			psw_ent          <= psw_ent_d;
			psw_bus_ctrl_iv  <= psw_bus_ctrl_iv_d;
			data_bus_ctrl_iv <= data_bus_ctrl_iv_d;
			addr_bus_ctrl_iv <= addr_bus_ctrl_iv_d;
			data_src_iv      <= data_src_iv_d;
			addr_src_iv      <= addr_src_iv_d;
			data_dst_iv      <= data_dst_iv_d;
		end
	end

endmodule

`default_nettype wire

// ==== source/iv_ctrl_pkg.sv ====
`default_nettype none

package iv_ctrl_pkg;

	typedef enum logic [2:0] {
		seq_idle         = 3'd0,	// No sequence selected
		seq_entry        = 3'd1,	// Full interrupt or trap entry
		seq_entry_fault  = 3'd2,	// Trap with a lower vector priority
		seq_return_pop   = 3'd3,	// Return that restores the stacked state
		seq_return_chain = 3'd4		// Return that chains into a pending PIC request
	} seq_kind_e;

	// Instruction types presented in place of the decoder's
	localparam logic [6:0] inst_ld_w    = 7'd33;	// LD.W
	localparam logic [6:0] inst_st_w    = 7'd34;	// ST.W
	localparam logic [6:0] inst_mov_w   = 7'd21;	// MOV.W
	localparam logic [6:0] inst_invalid = 7'd50;	// Ends the CPU cycle without a datapath op

	// Register file selects
	localparam logic [4:0] reg_lr       = 5'd5;
	localparam logic [4:0] reg_sp       = 5'd6;
	localparam logic [4:0] reg_pc       = 5'd7;
	localparam logic [4:0] reg_const_m1 = 5'd15;	// Constant #FFFF
	localparam logic [4:0] reg_temp     = 5'd16;	// Holds the vector PSW during entry

	// Data and address bus control
	localparam logic [6:0] bus_idle        = 7'b1111111;
	localparam logic [6:0] dbus_mdr_in     = 7'b0000001;	// MDR to register file
	localparam logic [6:0] dbus_to_mdr     = 7'b0001000;	// Register to MDR
	localparam logic [6:0] dbus_psw_to_mdr = 7'b0100000;	// PSW to MDR
	localparam logic [6:0] dbus_cex_to_mdr = 7'b0101000;	// CEX state to MDR
	localparam logic [6:0] dbus_reg_move   = 7'b0001001;	// Register to register
	localparam logic [6:0] dbus_none       = 7'b0111111;	// No register transfer on the data bus
	localparam logic [6:0] abus_sp         = 7'b0001000;	// SP to MAR
	localparam logic [6:0] abus_vector     = 7'b0100000;	// Vector table address to MAR

	// Vector table word select
	localparam logic [1:0] psw_ent_psw   = 2'b00;	// PSW word of the vector
	localparam logic [1:0] psw_ent_entry = 2'b10;	// Handler entry point

	// PSW bus control
	localparam logic [1:0] psw_bus_idle  = 2'b11;
	localparam logic [1:0] psw_from_mdr  = 2'b01;	// PSW loaded from MDR
	localparam logic [1:0] psw_from_temp = 2'b10;	// PSW loaded from temp register

endpackage

`default_nettype wire

// ==== source/iv_psw_pkg.sv ====
`default_nettype none

package iv_psw_pkg;

	typedef logic [2:0] pri_t;	// CPU and device priority level

	// PSW seen as a raw bus word or as its fields
	typedef union packed {
		logic [15:0] raw;
		struct packed {
			pri_t       prev_pri;	// Priority before the current handler
			logic [4:0] spare;
			pri_t       curr_pri;	// Running priority
			logic       flt;		// Fault flag
			logic       slp;		// Sleep bit
			logic       n;
			logic       z;
			logic       c;
		} fld;
	} iv_psw_u;

	// Layout of the PIC input byte
	localparam int unsigned pic_pend_bit = 7;	// Request pending
	localparam int unsigned pic_pri_hi   = 6;	// Requesting priority, upper bit
	localparam int unsigned pic_pri_lo   = 4;	// Requesting priority, lower bit

endpackage

`default_nettype wire

// ==== source/iv_step_counter.sv ====
`default_nettype none

module iv_step_counter #(
	parameter int STEP_W = 4
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              start,		// Begin at step 1
	input  logic              stall,		// Datapath not ready, hold the step
	input  logic              seq_done,		// Current step is the last one
	output logic [STEP_W-1:0] step,			// 0 when idle
	output logic              busy
);

	logic advance;

	assign advance = busy & ~stall;	// Step is consumed this cycle

	always_ff @(posedge clk) begin
		if (rst) begin
			step <= '0;
			busy <= 1'b0;
		end else if (start) begin
			step <= STEP_W'(1);
			busy <= 1'b1;
		end else if (advance) begin
			if (seq_done) begin				// Last step taken, back to idle
				step <= '0;
				busy <= 1'b0;
			end else begin
				step <= step + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/pic_request_latch.sv ====
`default_nettype none

module pic_request_latch (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   iv_enter,		// Entry request pulse
	input  logic                   iv_return,		// Return request pulse
	input  logic                   svc_inst,		// Entry is caused by a trap instruction
	input  iv_psw_pkg::iv_psw_u    cur_psw,
	input  iv_psw_pkg::iv_psw_u    vect_psw,
	input  logic [7:0]             pic_in,
	input  logic                   busy,
	output logic                   start,			// One cycle after an accepted request
	output iv_ctrl_pkg::seq_kind_e kind
);
	import iv_ctrl_pkg::*;
	import iv_psw_pkg::*;

	logic accept;
	logic trap_fault;
	logic chain_pend;
	pri_t pic_pri;

	// A start already in flight also counts as busy
	assign accept = (iv_enter | iv_return) & ~busy & ~start;

	assign pic_pri = pic_in[pic_pri_hi:pic_pri_lo];	// Priority of the pending PIC request

	// Trap into a handler of lower priority than the running code
	assign trap_fault = svc_inst && (vect_psw.fld.curr_pri < cur_psw.fld.curr_pri);

	// Pending request below the priority being restored
	assign chain_pend = pic_in[pic_pend_bit] && (pic_pri < cur_psw.fld.prev_pri);

	always_ff @(posedge clk) begin
		if (rst) begin
			start <= 1'b0;
			kind  <= seq_idle;
		end else begin
			start <= accept;
			if (accept) begin						// Kind stays put until the next request
				if (iv_enter) begin					// Entry wins over a same-cycle return
					kind <= trap_fault ? seq_entry_fault : seq_entry;
				end else begin
					kind <= chain_pend ? seq_return_chain : seq_return_pop;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb/int_vect_ref.svh ====
`ifndef INT_VECT_REF_SVH
`define INT_VECT_REF_SVH

// Control word in DUT output order, MSB first
typedef struct packed {
	logic       operands, word_byte, inc_iv, dec_iv, prpo_iv;
	logic       iv_cpu_rst, psw_entry_update, clear_cex, load_cex;
	logic       clr_slp_bit, rec_pre_pri, call_pri_flt, use_pic_vect;
	logic [6:0] inst_type;
	logic [1:0] psw_ent, psw_bus_ctrl_iv;
	logic [6:0] data_bus_ctrl_iv, addr_bus_ctrl_iv;
	logic [4:0] data_src_iv, addr_src_iv, data_dst_iv;
} ctrl_word_t;

function automatic ctrl_word_t idle_word();
	ctrl_word_t w;
	w = '0;
	w.inst_type        = inst_invalid;
	w.psw_ent          = psw_ent_psw;
	w.psw_bus_ctrl_iv  = psw_bus_idle;
	w.data_bus_ctrl_iv = bus_idle;
	w.addr_bus_ctrl_iv = bus_idle;
	return w;
endfunction

function automatic int ref_len(input seq_kind_e k);
	case (k)
		seq_entry:        return 9;
		seq_entry_fault:  return 2;
		seq_return_pop:   return 5;
		seq_return_chain: return 4;
		default:          return 0;
	endcase
endfunction

// Sequence picked for a request, entry taking precedence
function automatic seq_kind_e ref_kind(input bit enter, input bit svc,
		input iv_psw_u cp, input iv_psw_u vp, input logic [7:0] pic);
	if (enter) begin
		return (svc && (vp.fld.curr_pri < cp.fld.curr_pri)) ? seq_entry_fault : seq_entry;
	end
	if (pic[7] && (pic[6:4] < cp.fld.prev_pri)) begin	// Pending and below restored priority
		return seq_return_chain;
	end
	return seq_return_pop;
endfunction

function automatic ctrl_word_t ref_ctrl(input seq_kind_e k, input int step);
	ctrl_word_t w;
	w = idle_word();
	if ((k == seq_entry && step >= 1 && step <= 5) || (k == seq_entry_fault && step == 1)) begin
		if (step == 1) begin						// Vector PSW to temp
			w.inst_type        = inst_ld_w;
			w.data_bus_ctrl_iv = dbus_mdr_in;
			w.addr_bus_ctrl_iv = abus_vector;
			w.data_dst_iv      = reg_temp;
		end else begin								// Pushes, SP post-decrement
			w.inst_type        = inst_st_w;
			w.dec_iv           = 1'b1;
			w.addr_bus_ctrl_iv = abus_sp;
			w.addr_src_iv      = reg_sp;
			w.data_dst_iv      = reg_sp;
			w.data_src_iv      = (step == 2) ? reg_pc : reg_lr;
			w.data_bus_ctrl_iv = (step == 4) ? dbus_psw_to_mdr :
				(step == 5) ? dbus_cex_to_mdr : dbus_to_mdr;
			w.rec_pre_pri      = (step == 5);
		end
	end else if (k == seq_entry_fault && step == 2) begin
		w.call_pri_flt = 1'b1;
	end else if (k == seq_entry && step == 6) begin	// Temp to PSW
		w.psw_bus_ctrl_iv = psw_from_temp;
		w.data_src_iv     = reg_temp;
	end else if (k == seq_entry && step == 7) begin
		w.inst_type        = inst_ld_w;
		w.psw_entry_update = 1'b1;
		w.clr_slp_bit      = 1'b1;
		w.data_bus_ctrl_iv = dbus_mdr_in;
		w.addr_bus_ctrl_iv = abus_vector;
		w.psw_ent          = psw_ent_entry;
		w.data_dst_iv      = reg_pc;
	end else if (k == seq_entry && step == 8) begin	// -1 to LR
		w.inst_type        = inst_mov_w;
		w.data_bus_ctrl_iv = dbus_reg_move;
		w.data_src_iv      = reg_const_m1;
		w.data_dst_iv      = reg_lr;
	end else if (k == seq_entry && step == 9) begin
		w.clear_cex = 1'b1;
	end else if (k == seq_return_pop && step == 3) begin
		w.clr_slp_bit = 1'b1;
	end else if (k == seq_return_pop && step >= 1 && step <= 5) begin	// Pops, SP pre-increment
		w.inst_type        = inst_ld_w;
		w.prpo_iv          = 1'b1;
		w.inc_iv           = 1'b1;
		w.addr_bus_ctrl_iv = abus_sp;
		w.addr_src_iv      = reg_sp;
		w.data_src_iv      = (step == 2) ? 5'd0 : reg_sp;
		w.data_bus_ctrl_iv = (step <= 2) ? dbus_none : dbus_mdr_in;
		w.data_dst_iv      = (step <= 2) ? reg_sp : (step == 4) ? reg_lr : reg_pc;
		w.load_cex         = (step == 1);
		w.psw_bus_ctrl_iv  = (step == 2) ? psw_from_mdr : psw_bus_idle;
	end else if (k == seq_return_chain && step == 1) begin
		w.rec_pre_pri = 1'b1;
	end else if (k == seq_return_chain && (step == 2 || step == 4)) begin
		w.inst_type        = inst_ld_w;
		w.data_bus_ctrl_iv = dbus_mdr_in;
		w.addr_bus_ctrl_iv = abus_vector;
		w.use_pic_vect     = (step == 2);
		w.psw_ent          = (step == 4) ? psw_ent_entry : psw_ent_psw;
		w.data_dst_iv      = (step == 2) ? reg_temp : reg_pc;
	end else if (k == seq_return_chain && step == 3) begin
		w.psw_bus_ctrl_iv  = psw_from_temp;
		w.data_src_iv      = reg_temp;
		w.psw_entry_update = 1'b1;
		w.clr_slp_bit      = 1'b1;
	end
	w.operands   = (step >= 1) && (step < ref_len(k));	// All but the last step
	w.iv_cpu_rst = w.operands;
	return w;
endfunction

`endif

// ==== tb/int_vect_tb.sv ====
`default_nettype none

module int_vect_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import iv_ctrl_pkg::*;
	import iv_psw_pkg::*;

	`include "int_vect_ref.svh"

	logic       clk = 1'b0;
	logic       rst, iv_enter, iv_return, svc_inst, stall, busy;
	iv_psw_u    cur_psw, vect_psw;
	logic [7:0] pic_in;
	logic       operands, word_byte, inc_iv, dec_iv, prpo_iv;
	logic       iv_cpu_rst, psw_entry_update, clear_cex, load_cex;
	logic       clr_slp_bit, rec_pre_pri, call_pri_flt, use_pic_vect;
	logic [6:0] inst_type, data_bus_ctrl_iv, addr_bus_ctrl_iv;
	logic [1:0] psw_ent, psw_bus_ctrl_iv;
	logic [4:0] data_src_iv, addr_src_iv, data_dst_iv;
	ctrl_word_t got_word;

	int err_cnt   = 0;
	int test_cnt  = 0;
	int test_fail = 0;
	bit seq_over;

	// Field names and widths in ctrl_word_t order
	string fld_name[21] = '{"operands", "word_byte", "inc_iv", "dec_iv", "prpo_iv",
		"iv_cpu_rst", "psw_entry_update", "clear_cex", "load_cex", "clr_slp_bit",
		"rec_pre_pri", "call_pri_flt", "use_pic_vect", "inst_type", "psw_ent",
		"psw_bus_ctrl_iv", "data_bus_ctrl_iv", "addr_bus_ctrl_iv", "data_src_iv",
		"addr_src_iv", "data_dst_iv"};
	int fld_w[21] = '{1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 7, 2, 2, 7, 7, 5, 5, 5};

	int_vect_top #(.STEP_W(4)) i_dut (.*);

	assign got_word = {operands, word_byte, inc_iv, dec_iv, prpo_iv, iv_cpu_rst,
		psw_entry_update, clear_cex, load_cex, clr_slp_bit, rec_pre_pri, call_pri_flt,
		use_pic_vect, inst_type, psw_ent, psw_bus_ctrl_iv, data_bus_ctrl_iv,
		addr_bus_ctrl_iv, data_src_iv, addr_src_iv, data_dst_iv};

	always #5 clk = ~clk;

	task automatic compare_word(input ctrl_word_t exp_w);
		int         pos;
		logic [63:0] ev, gv, mask;
		pos = $bits(ctrl_word_t);
		for (int i = 0; i < 21; i++) begin
			pos  = pos - fld_w[i];
			mask = (64'd1 << fld_w[i]) - 1;
			ev   = (64'(exp_w) >> pos) & mask;
			gv   = (64'(got_word) >> pos) & mask;
			assert (gv === ev) else begin
				$display("error t=%0t %s expected %0h got %0h", $time, fld_name[i], ev, gv);
				err_cnt++;
			end
		end
	endtask

	task automatic check_busy(input logic exp_b);
		assert (busy === exp_b) else begin
			$display("error t=%0t busy expected %0b got %0b", $time, exp_b, busy);
			err_cnt++;
		end
	endtask

	task automatic check_idle(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			@(negedge clk);
			compare_word(idle_word());
			check_busy(1'b0);
		end
	endtask

	// Walks the steps from busy rise to the last word while stall cycles hold the step
	task automatic check_sequence(input seq_kind_e k);
		int         wait_cnt, step, busy_cnt, stalls, guard;
		bit         done;
		ctrl_word_t exp_w;
		wait_cnt = 0;
		while (busy !== 1'b1 && wait_cnt < 20) begin
			@(negedge clk);
			wait_cnt++;
		end
		if (busy !== 1'b1) begin
			$display("t=%0t busy never went high after the request", $time);
			err_cnt++;
		end else begin
			// Busy is seen two falling edges after the one that drives the request
			assert (wait_cnt - 1 == 2) else begin
				$display("error t=%0t busy_latency expected 2 got %0d", $time, wait_cnt - 1);
				err_cnt++;
			end
			step     = 1;
			busy_cnt = 1;
			stalls   = 0;
			done     = 1'b0;
			guard    = 0;
			while (!done && guard < 64) begin
				@(posedge clk);
				exp_w = ref_ctrl(k, step);				// Word loaded at this edge
				if (stall) begin
					stalls++;
				end else if (step == ref_len(k)) begin
					done = 1'b1;
				end else begin
					step++;
				end
				@(negedge clk);
				compare_word(exp_w);
				check_busy(!done);
				if (busy === 1'b1) busy_cnt++;
				guard++;
			end
			if (!done) begin
				$display("t=%0t sequence did not end within 64 cycles", $time);
				err_cnt++;
			end
			assert (busy_cnt == ref_len(k) + stalls) else begin
				$display("error t=%0t busy_cycles expected %0d got %0d", $time,
					ref_len(k) + stalls, busy_cnt);
				err_cnt++;
			end
			check_idle(3);								// No second sequence follows
		end
		seq_over = 1'b1;
	endtask

	task automatic run_seq(input string name, input bit enter, input bit ret, input bit svc,
			input iv_psw_u cp, input iv_psw_u vp, input logic [7:0] pic,
			input bit use_stall, input bit poke);
		int errs_before;
		int n;
		errs_before = err_cnt;
		seq_over    = 1'b0;
		n           = 0;
		fork
			check_sequence(ref_kind(enter, svc, cp, vp, pic));
			begin
				@(negedge clk);
				iv_enter  = enter;						// One cycle pulse
				iv_return = ret;
				svc_inst  = svc;
				cur_psw   = cp;
				vect_psw  = vp;
				pic_in    = pic;
				@(negedge clk);
				iv_enter  = 1'b0;
				iv_return = 1'b0;
				while (!seq_over && n < 100) begin
					iv_enter  = poke && (n == 2);		// Extra request in mid sequence
					iv_return = poke && (n == 2);
					stall     = use_stall && ($urandom_range(0, 2) == 0);
					@(negedge clk);
					n++;
				end
				iv_enter  = 1'b0;
				iv_return = 1'b0;
				stall     = 1'b0;
			end
		join
		test_cnt++;
		if (err_cnt != errs_before) test_fail++;
		$display("test %s %s", name, (err_cnt == errs_before) ? "ok" : "FAILED");
	endtask

	initial begin
		iv_psw_u    cp, vp;
		logic [7:0] pic;
		void'($urandom(32'h7c5f_8858));
		rst       = 1'b1;
		iv_enter  = 1'b0;
		iv_return = 1'b0;
		svc_inst  = 1'b0;
		stall     = 1'b0;
		cur_psw   = '0;
		vect_psw  = '0;
		pic_in    = '0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		check_idle(4);
		test_cnt++;
		$display("test %s %s", "reset_idle", (err_cnt == 0) ? "ok" : "FAILED");
		if (err_cnt != 0) test_fail++;

		cp.raw = 16'($urandom);
		vp.raw = 16'($urandom);
		run_seq("irq_entry", 1, 0, 0, cp, vp, 8'($urandom), 0, 0);
		cp.fld.curr_pri = pri_t'($urandom_range(1, 7));
		vp.fld.curr_pri = pri_t'($urandom_range(0, cp.fld.curr_pri - 1));
		run_seq("trap_fault", 1, 0, 1, cp, vp, 8'($urandom), 0, 0);
		vp.fld.curr_pri = pri_t'($urandom_range(cp.fld.curr_pri, 7));
		run_seq("trap_entry", 1, 0, 1, cp, vp, 8'($urandom), 0, 0);
		run_seq("enter_wins", 1, 1, 0, cp, vp, 8'($urandom), 0, 0);
		for (int i = 0; i < 8; i++) begin			// Even runs have no PIC request pending
			cp.raw = 16'($urandom);
			pic    = 8'($urandom);
			pic[7] = (i % 2 == 1);
			if (i % 4 == 1) begin					// Pending below the restored priority
				cp.fld.prev_pri = pri_t'($urandom_range(1, 7));
				pic[6:4]        = 3'($urandom_range(0, cp.fld.prev_pri - 1));
			end else if (i % 4 == 3) begin			// Pending at or above it
				pic[6:4] = 3'($urandom_range(cp.fld.prev_pri, 7));
			end
			run_seq($sformatf("return_%0d", i), 0, 1, 0, cp, vp, pic, 0, 0);
		end
		for (int i = 0; i < 4; i++) begin
			cp.raw = 16'($urandom);
			vp.raw = 16'($urandom);
			pic    = 8'($urandom);
			run_seq($sformatf("stall_%0d", i), i < 2, i >= 2, i == 1, cp, vp, pic, 1, 0);
		end
		cp.raw = 16'($urandom);
		run_seq("busy_drop", 1, 0, 0, cp, vp, 8'($urandom), 0, 1);

		$display("%0d tests, %0d failed, %0d check errors", test_cnt, test_fail, err_cnt);
		if (err_cnt == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire
